//--- verilog/zport_pkg.sv
// port and extended register addresses, reset values, shared bus and config structs
`default_nettype none

package zport_pkg;

  typedef logic [7:0] byte_t;

  // z80 i/o ports, low address byte
  localparam byte_t PORT_FE       = 8'hFE;
  localparam byte_t PORT_FD       = 8'hFD;
  localparam byte_t PORT_XT       = 8'hAF;  // #nnAF extended regs
  localparam byte_t PORT_FB_COVOX = 8'hFB;
  localparam byte_t PORT_KJOY     = 8'h1F;
  localparam byte_t PORT_KMOUSE   = 8'hDF;
  localparam byte_t PORT_SDCFG    = 8'h77;
  localparam byte_t PORT_SDDAT    = 8'h57;

  // extended register file, selected by high byte
  localparam byte_t XR_VCONF     = 8'h00;
  localparam byte_t XR_VPAGE     = 8'h01;
  localparam byte_t XR_GXOFFSL   = 8'h02;
  localparam byte_t XR_GXOFFSH   = 8'h03;
  localparam byte_t XR_GYOFFSL   = 8'h04;
  localparam byte_t XR_GYOFFSH   = 8'h05;
  localparam byte_t XR_TSCONF    = 8'h06;
  localparam byte_t XR_PALSEL    = 8'h07;
  localparam byte_t XR_BORDER    = 8'h0F;
  localparam byte_t XR_RAMPAGE   = 8'h10;  // #10..#13
  localparam byte_t XR_FMADDR    = 8'h15;
  localparam byte_t XR_SYSCONF   = 8'h20;
  localparam byte_t XR_MEMCONF   = 8'h21;
  localparam byte_t XR_FDDVIRT   = 8'h29;
  localparam byte_t XR_INTMASK   = 8'h2A;
  localparam byte_t XR_CACHECONF = 8'h2B;
  localparam byte_t XR_XSTAT     = 8'h00;  // read side only

  // reset values
  localparam byte_t      RST_MEMCONF  = 8'h04;  // no rom map
  localparam byte_t      RST_SYSCONF  = 8'h00;  // 3.5 MHz
  localparam byte_t      RST_INTMASK  = 8'h01;  // frame int only
  localparam byte_t      RST_RAMPAGE0 = 8'h00;
  localparam byte_t      RST_RAMPAGE1 = 8'h05;
  localparam byte_t      RST_RAMPAGE2 = 8'h02;
  localparam byte_t      RST_RAMPAGE3 = 8'h00;
  localparam logic [2:0] RST_SPI_CS   = 3'b111;

  // z80 bus as seen by the port block
  typedef struct packed {
    logic [15:0] a;
    byte_t       din;
    logic        iord;     // level
    logic        iord_s;   // one clk strobe
    logic        iowr_s;   // one clk strobe
    logic        wr;
    logic        regs_we;  // internal register write, address on low byte
    logic        opfetch;
  } zbus_t;

  // one-hot low byte hits plus the register address
  typedef struct packed {
    logic  fe;
    logic  xt;
    logic  fd;
    logic  covox;
    logic  kjoy;    // already masked in dos
    logic  kmouse;
    logic  sdcfg;
    logic  sddat;
    byte_t hoa;
  } port_sel_t;

  typedef struct packed {
    logic vconf;
    logic vpage;
    logic border;
    logic gx_offsl;
    logic gx_offsh;
    logic gy_offsl;
    logic gy_offsh;
    logic tsconf;
    logic palsel;
    logic zborder;  // #FE write
  } video_wr_t;

  typedef struct packed {
    byte_t       sysconf;
    byte_t       memconf;
    logic [3:0]  cacheconf;
    byte_t       intmask;
    byte_t       fddvirt;
    logic [4:0]  fmaddr;
    logic [31:0] xt_page;  // rampage 3..0
  } xt_cfg_t;

endpackage

`default_nettype wire

//--- verilog/zport_decode.sv
// zport_decode: low/high address decode into port hits, porthit and write strobes
`timescale 1ns/1ps
`default_nettype none

module zport_decode
  import zport_pkg::*;
(
  input  zbus_t     bus,
  input  logic      dos,
  output port_sel_t sel,
  output video_wr_t video_wr,
  output logic      beeper_wr,
  output logic      covox_wr,
  output logic      xt_wr,
  output logic      xt_rd,
  output logic      p7ffd_req,
  output logic      sd_wr,
  output logic      sd_rd,
  output logic      porthit
);

  byte_t loa;

  assign loa = bus.a[7:0];

  // port table
  assign sel.fe     = (loa == PORT_FE);
  assign sel.xt     = (loa == PORT_XT);
  assign sel.fd     = (loa == PORT_FD);
  assign sel.covox  = (loa == PORT_FB_COVOX);
  assign sel.kjoy   = (loa == PORT_KJOY) && !dos;  // #1F belongs to the fdc in dos
  assign sel.kmouse = (loa == PORT_KMOUSE);
  assign sel.sdcfg  = (loa == PORT_SDCFG);
  assign sel.sddat  = (loa == PORT_SDDAT);

  // internal writes put the register number on the low byte
  assign sel.hoa = bus.regs_we ? bus.a[7:0] : bus.a[15:8];

  assign porthit = sel.fe || sel.xt || sel.fd || sel.covox
                || sel.kjoy || sel.kmouse || sel.sdcfg || sel.sddat;

  assign beeper_wr = sel.fe && bus.iowr_s;
  assign covox_wr  = sel.covox && bus.iowr_s;

  assign xt_wr = (sel.xt && bus.iowr_s) || bus.regs_we;
  assign xt_rd = sel.xt && bus.iord_s;

  // #7FFD, a15 high is the AY port
  assign p7ffd_req = !bus.a[15] && sel.fd && bus.iowr_s;

  assign sd_wr = sel.sddat && bus.iowr_s;
  assign sd_rd = sel.sddat && bus.iord_s;

  // video registers
  assign video_wr.vconf    = xt_wr && (sel.hoa == XR_VCONF);
  assign video_wr.vpage    = xt_wr && (sel.hoa == XR_VPAGE);
  assign video_wr.border   = xt_wr && (sel.hoa == XR_BORDER);
  assign video_wr.gx_offsl = xt_wr && (sel.hoa == XR_GXOFFSL);
  assign video_wr.gx_offsh = xt_wr && (sel.hoa == XR_GXOFFSH);
  assign video_wr.gy_offsl = xt_wr && (sel.hoa == XR_GYOFFSL);
  assign video_wr.gy_offsh = xt_wr && (sel.hoa == XR_GYOFFSH);
  assign video_wr.tsconf   = xt_wr && (sel.hoa == XR_TSCONF);
  assign video_wr.palsel   = xt_wr && (sel.hoa == XR_PALSEL);
  assign video_wr.zborder  = beeper_wr;  // spectrum border shares #FE

endmodule

`default_nettype wire

//--- verilog/xt_regs.sv
// xt_regs: extended configuration registers, #7FFD paging, lock128 modes and lock48
`timescale 1ns/1ps
`default_nettype none

module xt_regs
  import zport_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  zbus_t     bus,
  input  port_sel_t sel,
  input  logic      xt_wr,
  input  logic      p7ffd_req,
  output xt_cfg_t   cfg,
  output logic      p7ffd_wr
);

  byte_t      rampage [0:3];
  byte_t      sysconf;
  byte_t      memconf;
  logic [3:0] cacheconf;
  byte_t      intmask;
  byte_t      fddvirt;
  logic [4:0] fmaddr;

  logic       m1_lock128;  // from last opcode fetch
  logic       lock48;
  logic       lock_mode2;
  logic       lock_mode3;
  logic       lock128;
  byte_t      page_7ffd;

  // memconf[7:6] selects how #7FFD bits 7:6 reach the page
  assign lock_mode2 = (memconf[7:6] == 2'b10);
  assign lock_mode3 = (memconf[7:6] == 2'b11);
  assign lock128    = lock_mode3 ? 1'b0 : (lock_mode2 ? m1_lock128 : memconf[6]);

  always_comb
  begin
    if (lock_mode3)
      page_7ffd = {2'b00, bus.din[5], bus.din[7:6], bus.din[2:0]};  // 1024k
    else
      page_7ffd = {3'b000, (lock128 ? 2'b00 : bus.din[7:6]), bus.din[2:0]};
  end

  assign p7ffd_wr = p7ffd_req && !lock48;

  // mode 2 lock, opcode with equal top bits keeps 128k
  always_ff @(posedge clk)
  begin
    if (rst)
      m1_lock128 <= 1'b0;
    else if (bus.opfetch)
      m1_lock128 <= !(bus.din[7] ^ bus.din[6]);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (p7ffd_wr && !lock_mode3)
      lock48 <= bus.din[5];  // sticks until reset
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rampage[0] <= RST_RAMPAGE0;
      rampage[1] <= RST_RAMPAGE1;
      rampage[2] <= RST_RAMPAGE2;
      rampage[3] <= RST_RAMPAGE3;
      sysconf    <= RST_SYSCONF;
      memconf    <= RST_MEMCONF;
      cacheconf  <= 4'h0;   // no cache
      intmask    <= RST_INTMASK;
      fddvirt    <= 8'h00;
      fmaddr     <= 5'h00;  // fm window off
    end
    else if (p7ffd_wr)
    begin
      memconf[0] <= bus.din[4];  // rom select
      rampage[3] <= page_7ffd;
    end
    else if (xt_wr)
    begin
      if (sel.hoa[7:2] == XR_RAMPAGE[7:2])
        rampage[sel.hoa[1:0]] <= bus.din;

      if (sel.hoa == XR_FMADDR)
        fmaddr <= bus.din[4:0];

      if (sel.hoa == XR_SYSCONF)
      begin
        sysconf   <= bus.din;
        cacheconf <= {4{bus.din[2]}};  // old cache bit covers all windows
      end

      if (sel.hoa == XR_CACHECONF)
        cacheconf <= bus.din[3:0];

      if (sel.hoa == XR_MEMCONF)
        memconf <= bus.din;

      if (sel.hoa == XR_FDDVIRT)
        fddvirt <= bus.din;

      if (sel.hoa == XR_INTMASK)
        intmask <= bus.din;
    end
  end

  assign cfg = '{
    sysconf:   sysconf,
    memconf:   memconf,
    cacheconf: cacheconf,
    intmask:   intmask,
    fddvirt:   fddvirt,
    fmaddr:    fmaddr,
    xt_page:   {rampage[3], rampage[2], rampage[1], rampage[0]}
  };

endmodule

`default_nettype wire

//--- verilog/sd_ctrl.sv
// sd_ctrl: SD chip select register, SPI start strobe and outgoing SPI data
`timescale 1ns/1ps
`default_nettype none

module sd_ctrl
  import zport_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  zbus_t     bus,
  input  port_sel_t sel,
  input  logic      sd_wr,
  input  logic      sd_rd,
  output logic      sdcs_n,
  output logic      sd2cs_n,
  output logic      sd_start,
  output byte_t     sd_datain
);

  logic [1:0] cs_n;  // {sd2, sd}
  logic       sdcfg_wr;

  assign sdcfg_wr = sel.sdcfg && bus.iowr_s;

  // z-controller style config, bit 2 is unused here
  always_ff @(posedge clk)
  begin
    if (rst)
      cs_n <= {RST_SPI_CS[2], RST_SPI_CS[0]};
    else if (sdcfg_wr)
      cs_n <= {~bus.din[3], bus.din[1]};
  end

  assign sdcs_n  = cs_n[0];
  assign sd2cs_n = cs_n[1];

  assign sd_start = sd_wr || sd_rd;  // every #57 access runs one byte

  // reads shift out #FF
  assign sd_datain = bus.wr ? bus.din : 8'hFF;

endmodule

`default_nettype wire

//--- verilog/port_readback.sv
// port_readback: i/o read data multiplexer and power-up status flag
`timescale 1ns/1ps
`default_nettype none

module port_readback
  import zport_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  zbus_t      bus,
  input  port_sel_t  sel,
  input  logic       xt_rd,
  input  xt_cfg_t    cfg,
  input  logic [4:0] keys_in,     // #FE key columns
  input  logic       tape_read,
  input  byte_t      mus_in,      // #xxDF
  input  byte_t      kj_in,       // #1F
  input  byte_t      sd_dataout,
  output byte_t      dout
);

  logic pwr_up;
  logic xstat_rd;

  assign xstat_rd = xt_rd && (sel.hoa == XR_XSTAT);

  // set by reset, first status read clears it
  always_ff @(posedge clk)
  begin
    if (rst)
      pwr_up <= 1'b1;
    else if (xstat_rd)
      pwr_up <= 1'b0;
  end

  always_comb
  begin
    dout = 8'hFF;  // unmapped ports and #7FFD, which is write only
    if (sel.fe)
      dout = {1'b1, tape_read, 1'b1, keys_in};
    else if (sel.xt)
    begin
      if (sel.hoa == XR_XSTAT)
        dout = {1'b0, pwr_up, 6'b000000};  // version fields read 0
      else if (sel.hoa == (XR_RAMPAGE + 8'd2))
        dout = cfg.xt_page[23:16];
      else if (sel.hoa == (XR_RAMPAGE + 8'd3))
        dout = cfg.xt_page[31:24];
    end
    else if (sel.kmouse)
      dout = mus_in;
    else if (sel.kjoy)
      dout = kj_in;
    else if (sel.sdcfg)
      dout = 8'h00;  // card present, not write protected
    else if (sel.sddat)
      dout = sd_dataout;
  end

endmodule

`default_nettype wire

//--- verilog/zports.sv
// zports: top level of the z80 port block, decode, registers, SD control and readback
`timescale 1ns/1ps
`default_nettype none

module zports
  import zport_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  zbus_t      bus,
  input  logic       dos,
  input  logic [4:0] keys_in,
  input  logic       tape_read,
  input  byte_t      mus_in,
  input  byte_t      kj_in,
  input  byte_t      sd_dataout,
  output byte_t      dout,
  output logic       dataout,
  output logic       porthit,
  output xt_cfg_t    cfg,
  output video_wr_t  video_wr,
  output logic       beeper_wr,
  output logic       covox_wr,
  output logic       p7ffd_wr,    // also the spectrum screen page strobe
  output logic       sdcs_n,
  output logic       sd2cs_n,
  output logic       sd_start,
  output byte_t      sd_datain
);

  port_sel_t sel;
  logic      xt_wr;
  logic      xt_rd;
  logic      p7ffd_req;
  logic      sd_wr;
  logic      sd_rd;

  assign dataout = porthit && bus.iord;  // z80 bus driven only on own ports

  zport_decode decode_i (
    .bus       (bus),
    .dos       (dos),
    .sel       (sel),
    .video_wr  (video_wr),
    .beeper_wr (beeper_wr),
    .covox_wr  (covox_wr),
    .xt_wr     (xt_wr),
    .xt_rd     (xt_rd),
    .p7ffd_req (p7ffd_req),
    .sd_wr     (sd_wr),
    .sd_rd     (sd_rd),
    .porthit   (porthit)
  );

  xt_regs regs_i (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus),
    .sel       (sel),
    .xt_wr     (xt_wr),
    .p7ffd_req (p7ffd_req),
    .cfg       (cfg),
    .p7ffd_wr  (p7ffd_wr)
  );

  sd_ctrl sd_i (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus),
    .sel       (sel),
    .sd_wr     (sd_wr),
    .sd_rd     (sd_rd),
    .sdcs_n    (sdcs_n),
    .sd2cs_n   (sd2cs_n),
    .sd_start  (sd_start),
    .sd_datain (sd_datain)
  );

  port_readback readback_i (
    .clk        (clk),
    .rst        (rst),
    .bus        (bus),
    .sel        (sel),
    .xt_rd      (xt_rd),
    .cfg        (cfg),
    .keys_in    (keys_in),
    .tape_read  (tape_read),
    .mus_in     (mus_in),
    .kj_in      (kj_in),
    .sd_dataout (sd_dataout),
    .dout       (dout)
  );

endmodule

`default_nettype wire

//--- dv/tb_util.svh
// Galois LFSR step and the value check task
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// 16 bit Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// stops the run at the first mismatch
task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp)
  begin
    $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    $display("*** FAILED ***");
    $fatal(1, "value mismatch on %s", name);
  end
endtask

`endif

//--- dv/zports_tb.sv
// zports testbench: clock, reset, LFSR random stimulus, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module zports_tb
  import zport_pkg::*;
();

  localparam int N_PHASES   = 4;    // each phase starts with a reset
  localparam int N_OPS      = 600;
  localparam int CLK_NS     = 40;
  localparam int TIMEOUT_NS = N_PHASES * (N_OPS + 16) * CLK_NS + 4000;
  localparam logic [31:0] MISC_PORTS = {PORT_FE, PORT_FB_COVOX, PORT_KJOY, PORT_KMOUSE};

  logic       clk;
  logic       rst;
  zbus_t      bus;
  logic       dos;
  logic [4:0] keys_in;
  logic       tape_read;
  byte_t      mus_in;
  byte_t      kj_in;
  byte_t      sd_dataout;
  byte_t      dout;
  byte_t      sd_datain;
  logic       dataout;
  logic       porthit;
  logic       beeper_wr;
  logic       covox_wr;
  logic       p7ffd_wr;
  logic       sdcs_n;
  logic       sd2cs_n;
  logic       sd_start;
  xt_cfg_t    cfg;
  video_wr_t  video_wr;

  // reference model state
  byte_t       m_rampage [0:3];
  byte_t       m_sysconf;
  byte_t       m_memconf;
  byte_t       m_intmask;
  byte_t       m_fddvirt;
  logic [3:0]  m_cacheconf;
  logic [4:0]  m_fmaddr;
  logic        m_m1lock;
  logic        m_lock48;
  logic        m_pwr;
  logic        m_sdcs_n;
  logic        m_sd2cs_n;
  logic [15:0] lfsr;
  byte_t       last_dout;  // dout seen by the last apply

  `include "tb_util.svh"

  zports zports_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired before the test sequence finished");
  end

  // n bits from the LFSR, one step per bit
  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  task automatic model_reset();
    m_rampage[0] = RST_RAMPAGE0;
    m_rampage[1] = RST_RAMPAGE1;
    m_rampage[2] = RST_RAMPAGE2;
    m_rampage[3] = RST_RAMPAGE3;
    m_sysconf    = RST_SYSCONF;
    m_memconf    = RST_MEMCONF;
    m_intmask    = RST_INTMASK;
    m_fddvirt    = 8'h00;
    m_cacheconf  = 4'h0;
    m_fmaddr     = 5'h00;
    m_m1lock     = 1'b0;
    m_lock48     = 1'b0;
    m_pwr        = 1'b1;
    m_sdcs_n     = 1'b1;
    m_sd2cs_n    = 1'b1;
  endtask

  task automatic do_reset();
    @(negedge clk);
    bus = '0;
    rst = 1'b1;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    model_reset();
  endtask

  // idle bus straight after reset
  task automatic check_reset_state();
    check("xt_page", cfg.xt_page, 32'h00020500);
    check("memconf", cfg.memconf, 8'h04);
    check("sysconf", cfg.sysconf, 8'h00);
    check("intmask", cfg.intmask, 8'h01);
    check("sdcs_n", sdcs_n, 1'b1);
    check("sd2cs_n", sd2cs_n, 1'b1);
    check("video_wr", video_wr, '0);
    check("beeper_wr", beeper_wr, 1'b0);
    check("covox_wr", covox_wr, 1'b0);
    check("p7ffd_wr", p7ffd_wr, 1'b0);
    check("sd_start", sd_start, 1'b0);
  endtask

  // drive on the falling edge, compare and step the model on the rising edge
  task automatic apply(input zbus_t b);
    byte_t     loa;
    byte_t     hoa;
    byte_t     e_dout;
    byte_t     page;
    logic      h_fe;
    logic      h_xt;
    logic      h_fd;
    logic      h_cov;
    logic      h_joy;
    logic      h_mus;
    logic      h_sdc;
    logic      h_sdd;
    logic      e_hit;
    logic      e_xtwr;
    logic      e_p7wr;
    logic      lk;
    video_wr_t e_vid;
    @(negedge clk);
    bus        = b;
    dos        = rnd(1);
    keys_in    = rnd(5);
    tape_read  = rnd(1);
    mus_in     = rnd(8);
    kj_in      = rnd(8);
    sd_dataout = rnd(8);
    @(posedge clk);
    loa   = bus.a[7:0];
    hoa   = bus.regs_we ? loa : bus.a[15:8];
    h_fe  = (loa == PORT_FE);
    h_xt  = (loa == PORT_XT);
    h_fd  = (loa == PORT_FD);
    h_cov = (loa == PORT_FB_COVOX);
    h_joy = (loa == PORT_KJOY) && !dos;  // joystick hidden in dos
    h_mus = (loa == PORT_KMOUSE);
    h_sdc = (loa == PORT_SDCFG);
    h_sdd = (loa == PORT_SDDAT);
    e_hit  = h_fe || h_xt || h_fd || h_cov || h_joy || h_mus || h_sdc || h_sdd;
    e_xtwr = (h_xt && bus.iowr_s) || bus.regs_we;
    e_p7wr = !bus.a[15] && h_fd && bus.iowr_s && !m_lock48;
    e_vid.vconf    = e_xtwr && (hoa == XR_VCONF);
    e_vid.vpage    = e_xtwr && (hoa == XR_VPAGE);
    e_vid.border   = e_xtwr && (hoa == XR_BORDER);
    e_vid.gx_offsl = e_xtwr && (hoa == XR_GXOFFSL);
    e_vid.gx_offsh = e_xtwr && (hoa == XR_GXOFFSH);
    e_vid.gy_offsl = e_xtwr && (hoa == XR_GYOFFSL);
    e_vid.gy_offsh = e_xtwr && (hoa == XR_GYOFFSH);
    e_vid.tsconf   = e_xtwr && (hoa == XR_TSCONF);
    e_vid.palsel   = e_xtwr && (hoa == XR_PALSEL);
    e_vid.zborder  = h_fe && bus.iowr_s;
    e_dout = 8'hFF;
    if (h_fe)
      e_dout = {1'b1, tape_read, 1'b1, keys_in};
    else if (h_xt && (hoa == XR_XSTAT))
      e_dout = {1'b0, m_pwr, 6'd0};
    else if (h_xt && (hoa == XR_RAMPAGE + 8'd2))
      e_dout = m_rampage[2];
    else if (h_xt && (hoa == XR_RAMPAGE + 8'd3))
      e_dout = m_rampage[3];
    else if (h_mus)
      e_dout = mus_in;
    else if (h_joy)
      e_dout = kj_in;
    else if (h_sdc)
      e_dout = 8'h00;
    else if (h_sdd)
      e_dout = sd_dataout;
    check("porthit", porthit, e_hit);
    check("dataout", dataout, e_hit && bus.iord);
    check("dout", dout, e_dout);
    check("beeper_wr", beeper_wr, h_fe && bus.iowr_s);
    check("covox_wr", covox_wr, h_cov && bus.iowr_s);
    check("p7ffd_wr", p7ffd_wr, e_p7wr);
    check("video_wr", video_wr, e_vid);
    check("sd_start", sd_start, h_sdd && (bus.iowr_s || bus.iord_s));
    check("sd_datain", sd_datain, bus.wr ? bus.din : 8'hFF);
    check("sdcs_n", sdcs_n, m_sdcs_n);
    check("sd2cs_n", sd2cs_n, m_sd2cs_n);
    check("xt_page", cfg.xt_page, {m_rampage[3], m_rampage[2], m_rampage[1], m_rampage[0]});
    check("sysconf", cfg.sysconf, m_sysconf);
    check("memconf", cfg.memconf, m_memconf);
    check("cacheconf", cfg.cacheconf, m_cacheconf);
    check("intmask", cfg.intmask, m_intmask);
    check("fddvirt", cfg.fddvirt, m_fddvirt);
    check("fmaddr", cfg.fmaddr, m_fmaddr);
    last_dout = dout;

    // #7FFD page from the lock mode in memconf[7:6]
    lk = (m_memconf[7:6] == 2'b10) ? m_m1lock : m_memconf[6];
    if (m_memconf[7:6] == 2'b11)
      page = {2'b00, bus.din[5], bus.din[7:6], bus.din[2:0]};
    else
      page = {3'b000, (lk ? 2'b00 : bus.din[7:6]), bus.din[2:0]};
    if (e_p7wr)
    begin
      if (m_memconf[7:6] != 2'b11)
        m_lock48 = bus.din[5];
      m_memconf[0] = bus.din[4];
      m_rampage[3] = page;
    end
    else if (e_xtwr)
    begin
      case (hoa)
        XR_RAMPAGE, XR_RAMPAGE + 8'd1, XR_RAMPAGE + 8'd2, XR_RAMPAGE + 8'd3:
          m_rampage[hoa - XR_RAMPAGE] = bus.din;
        XR_FMADDR:    m_fmaddr = bus.din[4:0];
        XR_SYSCONF:
        begin
          m_sysconf   = bus.din;
          m_cacheconf = {4{bus.din[2]}};
        end
        XR_CACHECONF: m_cacheconf = bus.din[3:0];
        XR_MEMCONF:   m_memconf = bus.din;
        XR_FDDVIRT:   m_fddvirt = bus.din;
        XR_INTMASK:   m_intmask = bus.din;
        default:      ;
      endcase
    end
    if (bus.opfetch)
      m_m1lock = (bus.din[7] == bus.din[6]);
    if (h_sdc && bus.iowr_s)
    begin
      m_sdcs_n  = bus.din[1];
      m_sd2cs_n = !bus.din[3];
    end
    if (h_xt && bus.iord_s && (hoa == XR_XSTAT))
      m_pwr = 1'b0;
  endtask

  task automatic random_op();
    zbus_t      b;
    logic [2:0] kind;
    logic [1:0] strobe;
    kind   = rnd(3);
    strobe = rnd(2);
    b      = '0;
    b.din  = rnd(8);
    b.a    = rnd(16);
    case (kind)
      3'd0, 3'd1:
      begin
        b.a[7:0]  = PORT_XT;
        b.a[15:8] = rnd(6);  // registers #00..#3F
      end
      3'd2:    b.a[7:0] = rnd(6);  // internal write, number on the low byte
      3'd3:
      begin
        b.a[7:0] = PORT_FD;
        b.a[15]  = (rnd(2) == 0);
        b.din[5] = (rnd(5) == 0);  // lock48 only now and then
      end
      3'd4:    b.a = {XR_MEMCONF, PORT_XT};
      3'd5:    b.a[7:0] = rnd(1) ? PORT_SDCFG : PORT_SDDAT;
      3'd6:    b.a[7:0] = MISC_PORTS[rnd(2) * 8 +: 8];
      default: ;
    endcase
    b.regs_we = (kind == 3'd2);
    if (!b.regs_we)
    begin
      b.iowr_s = strobe[0] || (kind == 3'd4);
      b.iord_s = (strobe == 2'd2) && (kind != 3'd4);
    end
    b.iord    = b.iord_s || (!b.iowr_s && !b.regs_we && rnd(1));
    b.wr      = b.iowr_s || (rnd(2) == 0);
    b.opfetch = (rnd(2) == 0);
    apply(b);
  endtask

  initial
  begin
    zbus_t xs;
    lfsr       = 16'd33772;
    rst        = 1'b1;
    bus        = '0;
    dos        = 1'b0;
    keys_in    = '0;
    tape_read  = 1'b0;
    mus_in     = '0;
    kj_in      = '0;
    sd_dataout = '0;
    xs         = '0;
    xs.a       = {XR_XSTAT, PORT_XT};
    xs.iord    = 1'b1;
    xs.iord_s  = 1'b1;
    for (int p = 0; p < N_PHASES; p++)
    begin
      do_reset();
      check_reset_state();
      apply(xs);
      check("dout first xstat", last_dout, 8'h40);
      apply(xs);
      check("dout second xstat", last_dout, 8'h00);
      repeat (N_OPS) random_op();
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+dv
verilog/zport_pkg.sv
verilog/zport_decode.sv
verilog/xt_regs.sv
verilog/sd_ctrl.sv
verilog/port_readback.sv
verilog/zports.sv
dv/zports_tb.sv

//--- Bender.yml
package:
  name: zports

sources:
  - files:
      - verilog/zport_pkg.sv
      - verilog/zport_decode.sv
      - verilog/xt_regs.sv
      - verilog/sd_ctrl.sv
      - verilog/port_readback.sv
      - verilog/zports.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/zports_tb.sv
